/* src/z80_bus_pkg.sv */
// z80 i/o bridge shared types: port operations, captured write records and the port bank
`default_nettype none

package z80_bus_pkg;

    // **************************************************
    // port bank geometry
    // **************************************************

    // number of output ports behind the bridge
    // port_sel in io_write_t must be wide enough to address all of them
    localparam int NUM_PORTS = 4;

    // **************************************************
    // write operation
    // **************************************************

    // address bits 1:0 of an OUT cycle choose how the data lands in the port
    typedef enum logic [1:0] {
        OP_WRITE  = 2'd0,   // replace the port value
        OP_SET    = 2'd1,   // or the data into the port
        OP_CLEAR  = 2'd2,   // clear the bits that are set in the data
        OP_TOGGLE = 2'd3    // xor the data into the port
    } port_op_e;

    // **************************************************
    // captured write record
    // **************************************************

    // one OUT cycle as seen by the phi-domain decoder
    // port_sel comes from address bits 3:2 and op from address bits 1:0
    // the whole record is 12 bits and crosses to wr_tick1 as one word
    typedef struct packed {
        logic [1:0] port_sel;
        port_op_e   op;
        logic [7:0] data;
    } io_write_t;

    // values of all output ports, port 0 in the low byte
    typedef logic [NUM_PORTS-1:0][7:0] port_bank_t;

endpackage : z80_bus_pkg

`default_nettype wire

/* src/z80_wr_strobe.sv */
// z80 OUT cycle decoder on phi, emits one write strobe and a captured record per cycle
`timescale 1ns/1ps
`default_nettype none

module z80_wr_strobe #(
    parameter int                  ADDR_WIDTH = 8,
    parameter logic [ADDR_WIDTH-5:0] BASE_ADDR = 4'h4
) (
    input  wire logic                  phi,
    input  wire logic                  reset,
    input  wire logic                  iorq_n,
    input  wire logic                  wr_n,
    input  wire logic [ADDR_WIDTH-1:0] addr,
    input  wire logic [7:0]            data,
    output logic                       cpu_wr,
    output z80_bus_pkg::io_write_t     cpu_rec
);

    import z80_bus_pkg::*;

    // IDLE waits for a write, T_WR has seen one qualifying edge,
    // FIRED is the strobe cycle, WAIT_END holds off until iorq_n goes high
    typedef enum logic [1:0] {
        IDLE,
        T_WR,
        FIRED,
        WAIT_END
    } state_e;

    state_e state;
    state_e state_nxt;
    logic   wr_hit;

    // an i/o write into our window, the upper address bits pick the block
    assign wr_hit = !iorq_n && !wr_n && (addr[ADDR_WIDTH-1:4] == BASE_ADDR);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (wr_hit)
                    state_nxt = T_WR;
            end
            T_WR: begin
                // second qualifying edge in a row fires the strobe
                if (wr_hit)
                    state_nxt = FIRED;
                else if (iorq_n)
                    state_nxt = IDLE;
                else
                    state_nxt = WAIT_END;
            end
            FIRED: begin
                // a long OUT cycle parks in WAIT_END so it cannot fire twice
                state_nxt = iorq_n ? IDLE : WAIT_END;
            end
            WAIT_END: begin
                if (iorq_n)
                    state_nxt = IDLE;
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge phi) begin
        if (reset)
            state <= IDLE;
        else
            state <= state_nxt;
    end

    // the record is captured on the same edge that enters FIRED
    always_ff @(posedge phi) begin
        if (state == T_WR && wr_hit) begin
            cpu_rec.port_sel <= addr[3:2];
            cpu_rec.op       <= port_op_e'(addr[1:0]);
            cpu_rec.data     <= data;
        end
    end

    // strobe is high for exactly the one phi cycle spent in FIRED
    assign cpu_wr = (state == FIRED);

endmodule : z80_wr_strobe

`default_nettype wire

/* src/sync_stretch.sv */
// pulse stretcher in the source clock and synchronizer with edge detect in the target clock
`timescale 1ns/1ps
`default_nettype none

module sync_stretch #(
    parameter int STRETCH_BITS = 1,
    parameter int SYNC_LEN     = 2
) (
    input  wire logic reset,
    input  wire logic clk1,
    input  wire logic clk2,
    input  wire logic in,
    output logic      out
);

    // **************************************************
    // source side, clk1
    // **************************************************

    logic [STRETCH_BITS-1:0] stretch_cnt;
    logic                    stretch;

    // each input pulse opens a level that lasts 2^STRETCH_BITS clk1 cycles
    // a new pulse while the level is up restarts the count
    always_ff @(posedge clk1) begin
        if (reset) begin
            stretch     <= 1'b0;
            stretch_cnt <= '0;
        end else if (in) begin
            stretch     <= 1'b1;
            stretch_cnt <= '0;
        end else if (stretch) begin
            stretch_cnt <= stretch_cnt + 1'b1;
            if (stretch_cnt == {STRETCH_BITS{1'b1}})
                stretch <= 1'b0;
        end
    end

    // **************************************************
    // target side, clk2
    // **************************************************

    logic [SYNC_LEN-1:0] sync_q;
    logic                sync_last;

    // first stage samples the stretched level asynchronously
    // the rest of the chain lets any metastability settle
    always_ff @(posedge clk2) begin
        if (reset) begin
            sync_q    <= '0;
            sync_last <= 1'b0;
        end else begin
            sync_q[0] <= stretch;
            for (int i = 1; i < SYNC_LEN; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
            sync_last <= sync_q[SYNC_LEN-1];
        end
    end

    // rising edge of the synchronized level, one clk2 cycle wide
    assign out = sync_q[SYNC_LEN-1] && !sync_last;

endmodule : sync_stretch

`default_nettype wire

/* src/z80_wr_cdc.sv */
// write record hold register in phi and strobe crossing into the wr_tick1 domain
`timescale 1ns/1ps
`default_nettype none

module z80_wr_cdc #(
    parameter int STRETCH_BITS = 1,
    parameter int SYNC_LEN     = 2
) (
    input  wire logic                   reset,
    input  wire logic                   clk1,          // cpu phi clock
    input  wire logic                   clk2,          // system clock, wr_tick1
    input  wire logic                   wr_tick1_in,   // write strobe in clk1
    input  wire z80_bus_pkg::io_write_t rec1,          // record valid with wr_tick1_in
    output logic                        wr_tick2,      // one clk2 cycle per write
    output z80_bus_pkg::io_write_t      rec2           // held record for clk2
);

    import z80_bus_pkg::*;

    // **************************************************
    // phi side hold register
    // **************************************************

    io_write_t rec_hold;

    // the record is loaded on the strobe and then left alone
    // the cpu spaces its writes past the crossing time, so the held value
    // is stable from before the stretched level rises until after wr_tick2
    always_ff @(posedge clk1) begin
        if (wr_tick1_in)
            rec_hold <= rec1;
    end

    // **************************************************
    // strobe crossing
    // **************************************************

    sync_stretch #(
        .STRETCH_BITS (STRETCH_BITS),
        .SYNC_LEN     (SYNC_LEN)
    ) sync_stretch_i (
        .reset (reset),
        .clk1  (clk1),
        .clk2  (clk2),
        .in    (wr_tick1_in),
        .out   (wr_tick2)
    );

    // clk2 reads the hold register directly
    // it is only looked at while wr_tick2 is high
    assign rec2 = rec_hold;

endmodule : z80_wr_cdc

`default_nettype wire

/* src/io_port_regs.sv */
// bank of four 8-bit output ports updated by write, set, clear or toggle in wr_tick1
`timescale 1ns/1ps
`default_nettype none

module io_port_regs (
    input  wire logic                   wr_tick1,
    input  wire logic                   reset,
    input  wire logic                   wr_tick2,
    input  wire z80_bus_pkg::io_write_t wr_rec,
    output z80_bus_pkg::port_bank_t     port_out
);

    import z80_bus_pkg::*;

    port_bank_t port_q;
    logic [7:0] port_cur;
    logic [7:0] port_nxt;

    // **************************************************
    // byte update for the selected port
    // **************************************************

    // current value of the port the write is aimed at
    assign port_cur = port_q[wr_rec.port_sel];

    always_comb begin
        case (wr_rec.op)
            OP_WRITE: begin
                // plain store of the data byte
                port_nxt = wr_rec.data;
            end
            OP_SET: begin
                // bits that are 1 in the data are forced on
                port_nxt = port_cur | wr_rec.data;
            end
            OP_CLEAR: begin
                // bits that are 1 in the data are forced off
                port_nxt = port_cur & ~wr_rec.data;
            end
            OP_TOGGLE: begin
                // bits that are 1 in the data flip
                port_nxt = port_cur ^ wr_rec.data;
            end
            default: begin
                port_nxt = port_cur;
            end
        endcase
    end

    // **************************************************
    // port registers
    // **************************************************

    // only the selected byte moves, the other ports hold their values
    always_ff @(posedge wr_tick1) begin
        if (reset) begin
            port_q <= '0;
        end else if (wr_tick2) begin
            port_q[wr_rec.port_sel] <= port_nxt;
        end
    end

    // ports drive the pins straight from the flops
    assign port_out = port_q;

endmodule : io_port_regs

`default_nettype wire

/* src/z80_io_bridge.sv */
// z80 i/o write bridge top: OUT decoder on phi, strobe crossing and wr_tick1 port bank
`timescale 1ns/1ps
`default_nettype none

module z80_io_bridge #(
    parameter int                    ADDR_WIDTH   = 8,
    parameter logic [ADDR_WIDTH-5:0] BASE_ADDR    = 4'h4,
    parameter int                    STRETCH_BITS = 1,
    parameter int                    SYNC_LEN     = 2
) (
    input  wire logic                  wr_tick1,
    input  wire logic                  phi,
    input  wire logic                  reset,
    input  wire logic                  iorq_n,
    input  wire logic                  wr_n,
    input  wire logic [ADDR_WIDTH-1:0] addr,
    input  wire logic [7:0]            data,
    output z80_bus_pkg::port_bank_t    port_out
);

    import z80_bus_pkg::*;

    // phi domain strobe and record from the decoder
    logic      cpu_wr;
    io_write_t cpu_rec;

    // wr_tick1 domain strobe and held record from the crossing
    logic      wr_tick2;
    io_write_t wr_rec;

    // **************************************************
    // cpu bus side, phi
    // **************************************************

    z80_wr_strobe #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .BASE_ADDR  (BASE_ADDR)
    ) z80_wr_strobe_i (
        .phi     (phi),
        .reset   (reset),
        .iorq_n  (iorq_n),
        .wr_n    (wr_n),
        .addr    (addr),
        .data    (data),
        .cpu_wr  (cpu_wr),
        .cpu_rec (cpu_rec)
    );

    // the record stays in phi, only the strobe is synchronized
    z80_wr_cdc #(
        .STRETCH_BITS (STRETCH_BITS),
        .SYNC_LEN     (SYNC_LEN)
    ) z80_wr_cdc_i (
        .reset       (reset),
        .clk1        (phi),
        .clk2        (wr_tick1),
        .wr_tick1_in (cpu_wr),
        .rec1        (cpu_rec),
        .wr_tick2    (wr_tick2),
        .rec2        (wr_rec)
    );

    // **************************************************
    // system side, wr_tick1
    // **************************************************

    io_port_regs io_port_regs_i (
        .wr_tick1 (wr_tick1),
        .reset    (reset),
        .wr_tick2 (wr_tick2),
        .wr_rec   (wr_rec),
        .port_out (port_out)
    );

endmodule : z80_io_bridge

`default_nettype wire

/* sim/tb_clock.sv */
// testbench clock and reset source, wr_tick1 at 8 ns, phi at 16 ns and a synchronous reset pulse
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int TICK_HALF    = 4,
    parameter int PHI_HALF     = 8,
    parameter int RESET_CYCLES = 3
) (
    output logic wr_tick1,
    output logic phi,
    output logic reset
);

    // system clock, 8 ns period
    initial begin
        wr_tick1 = 1'b0;
        forever #TICK_HALF wr_tick1 = ~wr_tick1;
    end

    // cpu clock, 16 ns period, rising edges fall on every other falling edge of wr_tick1
    initial begin
        phi = 1'b0;
        forever #PHI_HALF phi = ~phi;
    end

    // reset spans three wr_tick1 cycles and so covers at least one phi edge
    // it drops a nanosecond after the last rising edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge wr_tick1);
        #1;
        reset = 1'b0;
    end

endmodule : tb_clock

`default_nettype wire

/* sim/tb_z80_io_bridge.sv */
// testbench for the z80 i/o write bridge with a bus-cycle driver, a port model and checks
`timescale 1ns/1ps
`default_nettype none

module tb_z80_io_bridge;

    import z80_bus_pkg::*;

    localparam int          ADDR_WIDTH    = 8;
    localparam logic [3:0]  BASE_ADDR     = 4'h4;
    localparam int          STRETCH_BITS  = 1;
    localparam int          SYNC_LEN      = 2;
    localparam int          DRIVE_DLY     = 2;
    localparam int          IDLE_PHI      = 6;
    localparam int          MATCH_TIMEOUT = 64;
    localparam int          RESET_TIMEOUT = 32;
    localparam int          SETTLE_CYCLES = 20;
    localparam logic [31:0] SEED          = 32'h0cedd084;

    logic                  wr_tick1;
    logic                  phi;
    logic                  reset;
    logic                  iorq_n;
    logic                  wr_n;
    logic [ADDR_WIDTH-1:0] addr;
    logic [7:0]            data;
    port_bank_t            port_out;

    // what the four ports should hold, per the operation rules
    logic [7:0] model [NUM_PORTS];

    int checks;
    int errors;
    int tests_run;
    int tests_failed;
    int test_errors;

    tb_clock clock_i (
        .wr_tick1 (wr_tick1),
        .phi      (phi),
        .reset    (reset)
    );

    z80_io_bridge #(
        .ADDR_WIDTH   (ADDR_WIDTH),
        .BASE_ADDR    (BASE_ADDR),
        .STRETCH_BITS (STRETCH_BITS),
        .SYNC_LEN     (SYNC_LEN)
    ) z80_io_bridge_i (
        .wr_tick1 (wr_tick1),
        .phi      (phi),
        .reset    (reset),
        .iorq_n   (iorq_n),
        .wr_n     (wr_n),
        .addr     (addr),
        .data     (data),
        .port_out (port_out)
    );

    // **************************************************
    // port model
    // **************************************************

    // new port value from the old one, the operation and the data byte
    function automatic logic [7:0] apply_op(input logic [7:0] cur, input port_op_e op,
                                            input logic [7:0] d);
        if (op == OP_WRITE)
            return d;
        else if (op == OP_SET)
            return cur | d;
        else if (op == OP_CLEAR)
            return cur & ~d;
        else
            return cur ^ d;
    endfunction

    // packs the model bytes the way the bridge presents them, port 0 low
    function automatic port_bank_t expected_bank();
        port_bank_t bank;
        for (int p = 0; p < NUM_PORTS; p++) begin
            bank[p] = model[p];
        end
        return bank;
    endfunction

    // **************************************************
    // checks
    // **************************************************

    task automatic compare_ports(input port_bank_t exp_bank);
        checks++;
        assert (port_out === exp_bank) else begin
            $display("ERROR: port_out expected %08h actual %08h", exp_bank, port_out);
            errors++;
        end
    endtask

    // port_out moves on rising wr_tick1, so it is sampled on the falling edge
    task automatic wait_match();
        port_bank_t exp_bank;
        int         cycles;
        exp_bank = expected_bank();
        cycles   = 0;
        @(negedge wr_tick1);
        while (port_out !== exp_bank && cycles < MATCH_TIMEOUT) begin
            @(negedge wr_tick1);
            cycles++;
        end
        if (port_out !== exp_bank)
            $display("timeout: port_out did not reach the model value in %0d cycles",
                     MATCH_TIMEOUT);
        compare_ports(exp_bank);
    endtask

    // the ports must hold the model value on every cycle of the window
    task automatic check_stable(input int n);
        port_bank_t exp_bank;
        exp_bank = expected_bank();
        repeat (n) begin
            @(negedge wr_tick1);
            compare_ports(exp_bank);
        end
    endtask

    task automatic wait_reset_done();
        int cycles;
        cycles = 0;
        // reset is raised at time zero, so it is first looked at on a clock edge
        @(posedge wr_tick1);
        while (reset && cycles < RESET_TIMEOUT) begin
            @(posedge wr_tick1);
            cycles++;
        end
        if (reset) begin
            $display("timeout: reset was still high after %0d cycles", RESET_TIMEOUT);
            errors++;
        end
    endtask

    task automatic end_test(input int num, input string name);
        tests_run++;
        if (errors == test_errors) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", num, name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    // **************************************************
    // bus driver
    // **************************************************

    // one OUT cycle, strobes low for hold phi edges, then six idle phi cycles
    task automatic out_cycle(input logic [ADDR_WIDTH-1:0] a, input logic [7:0] d,
                             input int hold);
        @(posedge phi);
        #DRIVE_DLY;
        addr   = a;
        data   = d;
        iorq_n = 1'b0;
        wr_n   = 1'b0;
        repeat (hold) @(posedge phi);
        #DRIVE_DLY;
        iorq_n = 1'b1;
        wr_n   = 1'b1;
        repeat (IDLE_PHI) @(posedge phi);
    endtask

    // in-window write, address is base nibble, port select and operation
    task automatic port_write(input logic [1:0] port, input port_op_e op,
                              input logic [7:0] d, input int hold);
        logic [ADDR_WIDTH-1:0] a;
        a = {BASE_ADDR, port, op};
        out_cycle(a, d, hold);
        model[port] = apply_op(model[port], op, d);
        wait_match();
    endtask

    // **************************************************
    // test sequence
    // **************************************************

    initial begin
        int unsigned rnd;
        logic [3:0]  upper;

        // one seed for the whole run
        rnd          = $urandom(SEED);
        iorq_n       = 1'b1;
        wr_n         = 1'b1;
        addr         = '0;
        data         = '0;
        checks       = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_errors  = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            model[p] = 8'h00;
        end

        // all ports clear out of reset and nothing moves while the bus idles
        wait_reset_done();
        check_stable(SETTLE_CYCLES);
        end_test(1, "reset value");

        // plain writes, each port picks up its own byte
        port_write(2'd0, OP_WRITE, 8'h3c, 3);
        port_write(2'd1, OP_WRITE, 8'ha5, 3);
        port_write(2'd2, OP_WRITE, 8'h0f, 4);
        port_write(2'd3, OP_WRITE, 8'hf0, 5);
        end_test(2, "write each port");

        // read-modify-write operations on ports that already hold data
        port_write(2'd0, OP_SET, 8'h81, 3);
        port_write(2'd1, OP_CLEAR, 8'h21, 4);
        port_write(2'd2, OP_TOGGLE, 8'hff, 3);
        port_write(2'd3, OP_SET, 8'h0f, 3);
        port_write(2'd3, OP_CLEAR, 8'hc3, 6);
        port_write(2'd0, OP_TOGGLE, 8'h18, 3);
        end_test(3, "set clear toggle");

        // upper nibble off the base, the decoder must ignore these
        repeat (8) begin
            rnd   = $urandom();
            upper = rnd[3:0];
            if (upper == BASE_ADDR)
                upper = upper ^ 4'h8;
            out_cycle({upper, rnd[7:4]}, rnd[15:8], 3);
            check_stable(SETTLE_CYCLES);
        end
        end_test(4, "outside window");

        // a long toggle cycle must flip the bits only once
        port_write(2'd2, OP_TOGGLE, 8'h5a, 10);
        check_stable(SETTLE_CYCLES);
        end_test(5, "long toggle");

        // random port, operation, data and hold length
        repeat (40) begin
            rnd = $urandom();
            port_write(rnd[1:0], port_op_e'(rnd[3:2]), rnd[11:4], 3 + int'(rnd[14:12]));
        end
        end_test(6, "random writes");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule : tb_z80_io_bridge

`default_nettype wire

/* vlog.f */
src/z80_bus_pkg.sv
src/z80_wr_strobe.sv
src/sync_stretch.sv
src/z80_wr_cdc.sv
src/io_port_regs.sv
src/z80_io_bridge.sv
sim/tb_clock.sv
sim/tb_z80_io_bridge.sv

/* Makefile */
# verilator build and run of the z80 i/o bridge testbench

SRCS := $(wildcard src/*.sv sim/*.sv)
BIN  := obj_dir/Vtb_z80_io_bridge

.PHONY: all run clean

all: $(BIN)

# the binary is rebuilt only when a source or the file list changes
$(BIN): vlog.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_z80_io_bridge \
		--Mdir obj_dir -f vlog.f

# the run passes only if the pass line shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'RESULT: PASS'

clean:
	rm -rf obj_dir
